/* Bender.yml */
package:
  name: safe_lockstep

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/lockstep_pkg.sv
      - verilog/lockstep_csr.sv
      - verilog/lockstep_voter.sv
      - verilog/lockstep_comparator.sv
      - verilog/lockstep_bus_mux.sv
      - verilog/safe_lockstep_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - testbench/tb_clk_gen.sv
      - testbench/tb_safe_lockstep.sv

/* filelist.f */
+incdir+verilog
verilog/lockstep_pkg.sv
verilog/lockstep_csr.sv
verilog/lockstep_voter.sv
verilog/lockstep_comparator.sv
verilog/lockstep_bus_mux.sv
verilog/safe_lockstep_top.sv
testbench/tb_clk_gen.sv
testbench/tb_safe_lockstep.sv

/* testbench/tb_clk_gen.sv */
// *************************************************
// Testbench clock and reset
// Free running clock, active low reset pulse
// *************************************************

`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter int CLK_PERIOD = 20,
    parameter int RST_CYCLES = 8
) (
    output logic clk_o,
    output logic rst_no
);

    initial begin
        clk_o = 1'b0;
        forever #(CLK_PERIOD / 2) clk_o = ~clk_o;
    end

    // Release away from the rising edge
    initial begin
        rst_no = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_no = 1'b1;
    end

endmodule

`default_nettype wire

/* testbench/tb_safe_lockstep.sv */
// *************************************************
// Lockstep wrapper testbench
// Reference model of routing and registers, checked
// by assertions while the stimulus walks all modes
// *************************************************

`timescale 1ns/1ps
`default_nettype none

`include "lockstep_params.svh"

module tb_safe_lockstep;
    import lockstep_pkg::*;

    localparam int CLK_PERIOD  = 20;
    localparam int RST_CYCLES  = 8;
    localparam int TEST_CYCLES = 400;
    localparam int PW = $bits(data_req_t);
    localparam int IW = $bits(instr_req_t);
    localparam int RW = $bits(bus_resp_t);

    logic clk, rst_n;
    logic [`LS_APB_AW-1:0] paddr;
    logic psel, penable, pwrite, pready, pslverr, irq;
    logic [`LS_DATA_W-1:0] pwdata, prdata, exp_prdata;
    instr_req_t [`LS_NHARTS-1:0] core_instr_req, mem_instr_req, exp_mem_instr;
    data_req_t  [`LS_NHARTS-1:0] core_data_req, mem_data_req, exp_mem_data;
    bus_resp_t  [`LS_NHARTS-1:0] core_instr_resp, core_data_resp, exp_core_instr, exp_core_data;
    bus_resp_t  [`LS_NHARTS-1:0] mem_instr_resp, mem_data_resp;

    // Reference registers and decoded routing
    logic [1:0] ref_mode, ref_master, ref_pair, ref_irq_en;
    logic [1:0] eff_master, pair_a, pair_b, pair_c;
    logic ref_tmr_err, ref_dmr_err, ref_tmr_on, ref_dmr_on;
    logic [2:0] ref_err_id, vote_id;
    logic [PW-1:0] vote_instr, vote_data;
    logic tmr_err_now, dmr_err_now, apb_access, addr_mapped, status_wr, exp_irq;
    logic [31:0] lfsr;

    // Odd hart out, all ones when nobody agrees
    function automatic logic [2:0] outlier(input logic [PW-1:0] h0, h1, h2);
        if (h0 == h1 && h1 == h2) return 3'b000;
        if (h0 != h1 && h1 != h2 && h0 != h2) return 3'b111;
        return {h2 != h0 && h2 != h1, h1 != h0 && h1 != h2, h0 != h1 && h0 != h2};
    endfunction

    // Hart 0 wins unless it is the outlier
    function automatic logic [PW-1:0] majority(input logic [PW-1:0] h0, h1, h2);
        if (h1 == h2 && h0 != h1) return h1;
        return h0;
    endfunction

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic fail_check(input string what);
        $display("Error at %0t ns: %s", $time, what);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at first failing check");
    endtask

    tb_clk_gen #(.CLK_PERIOD(CLK_PERIOD), .RST_CYCLES(RST_CYCLES)) i_clk_gen (
        .clk_o  (clk),
        .rst_no (rst_n)
    );

    safe_lockstep_top i_dut (
        .clk_i             (clk),
        .rst_ni            (rst_n),
        .paddr_i           (paddr),
        .psel_i            (psel),
        .penable_i         (penable),
        .pwrite_i          (pwrite),
        .pwdata_i          (pwdata),
        .prdata_o          (prdata),
        .pready_o          (pready),
        .pslverr_o         (pslverr),
        .core_instr_req_i  (core_instr_req),
        .core_data_req_i   (core_data_req),
        .core_instr_resp_o (core_instr_resp),
        .core_data_resp_o  (core_data_resp),
        .mem_instr_req_o   (mem_instr_req),
        .mem_data_req_o    (mem_data_req),
        .mem_instr_resp_i  (mem_instr_resp),
        .mem_data_resp_i   (mem_data_resp),
        .interrupt_o       (irq)
    );

    assign ref_tmr_on  = (ref_mode == 2'd1);
    assign ref_dmr_on  = (ref_mode == 2'd2);
    assign eff_master  = (ref_master == 2'd3) ? 2'd0 : ref_master;
    assign apb_access  = psel && penable;
    assign addr_mapped = (paddr == `LS_REG_MODE) || (paddr == `LS_REG_STATUS) ||
                         (paddr == `LS_REG_IRQ_EN);
    assign status_wr   = apb_access && pwrite && (paddr == `LS_REG_STATUS);
    assign exp_irq     = (ref_tmr_err && ref_irq_en[0]) || (ref_dmr_err && ref_irq_en[1]);

    // First and second pair member, then the lone hart
    always_comb begin
        case (ref_pair)
            2'd1:    {pair_a, pair_b, pair_c} = {2'd1, 2'd2, 2'd0};
            2'd2:    {pair_a, pair_b, pair_c} = {2'd0, 2'd2, 2'd1};
            default: {pair_a, pair_b, pair_c} = {2'd0, 2'd1, 2'd2};
        endcase
    end

    assign vote_instr  = majority(PW'(core_instr_req[0]), PW'(core_instr_req[1]),
                                  PW'(core_instr_req[2]));
    assign vote_data   = majority(core_data_req[0], core_data_req[1], core_data_req[2]);
    assign vote_id     = outlier(PW'(core_instr_req[0]), PW'(core_instr_req[1]),
                                 PW'(core_instr_req[2])) |
                         outlier(core_data_req[0], core_data_req[1], core_data_req[2]);
    assign tmr_err_now = ref_tmr_on && (vote_id != 3'b000);
    assign dmr_err_now = ref_dmr_on && ((core_instr_req[pair_a] != core_instr_req[pair_b]) ||
                                        (core_data_req[pair_a] != core_data_req[pair_b]));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            {ref_mode, ref_master, ref_pair, ref_irq_en} <= '0;
            {ref_tmr_err, ref_dmr_err, ref_err_id} <= '0;
        end else begin
            if (apb_access && pwrite && paddr == `LS_REG_MODE) begin
                {ref_pair, ref_master, ref_mode} <= pwdata[5:0];
            end
            if (apb_access && pwrite && paddr == `LS_REG_IRQ_EN) begin
                ref_irq_en <= pwdata[1:0];
            end
            // A live error beats the clear
            if (tmr_err_now) begin
                ref_tmr_err <= 1'b1;
                ref_err_id  <= vote_id;
            end else if (status_wr) begin
                ref_tmr_err <= ref_tmr_err && !pwdata[0];
                ref_err_id  <= ref_err_id & ~pwdata[4:2];
            end
            if (dmr_err_now) begin
                ref_dmr_err <= 1'b1;
            end else if (status_wr && pwdata[1]) begin
                ref_dmr_err <= 1'b0;
            end
        end
    end

    always_comb begin
        exp_prdata = '0;
        if (paddr == `LS_REG_MODE) exp_prdata[5:0] = {ref_pair, ref_master, ref_mode};
        if (paddr == `LS_REG_STATUS) exp_prdata[4:0] = {ref_err_id, ref_dmr_err, ref_tmr_err};
        if (paddr == `LS_REG_IRQ_EN) exp_prdata[1:0] = ref_irq_en;
    end

    // Per port request source and per hart response source
    always_comb begin
        for (int k = 0; k < `LS_NHARTS; k++) begin
            exp_mem_instr[k]  = '0;
            exp_mem_data[k]   = '0;
            exp_core_instr[k] = mem_instr_resp[k];
            exp_core_data[k]  = mem_data_resp[k];
            if (ref_tmr_on) begin
                if (k == eff_master) begin
                    exp_mem_instr[k] = vote_instr[IW-1:0];
                    exp_mem_data[k]  = vote_data;
                end
                exp_core_instr[k] = mem_instr_resp[eff_master];
                exp_core_data[k]  = mem_data_resp[eff_master];
            end else if (ref_dmr_on) begin
                if (k < 2) begin
                    exp_mem_instr[k] = core_instr_req[(k == 0) ? pair_a : pair_c];
                    exp_mem_data[k]  = core_data_req[(k == 0) ? pair_a : pair_c];
                end
                exp_core_instr[k] = mem_instr_resp[(k == pair_c) ? 1 : 0];
                exp_core_data[k]  = mem_data_resp[(k == pair_c) ? 1 : 0];
            end else begin
                exp_mem_instr[k] = core_instr_req[k];
                exp_mem_data[k]  = core_data_req[k];
            end
        end
    end

    a_mem_instr: assert property (@(posedge clk) disable iff (!rst_n)
        mem_instr_req == exp_mem_instr) else fail_check("instruction port requests wrong");
    a_mem_data: assert property (@(posedge clk) disable iff (!rst_n)
        mem_data_req == exp_mem_data) else fail_check("data port requests wrong");
    a_core_instr: assert property (@(posedge clk) disable iff (!rst_n)
        core_instr_resp == exp_core_instr) else fail_check("instruction responses wrong");
    a_core_data: assert property (@(posedge clk) disable iff (!rst_n)
        core_data_resp == exp_core_data) else fail_check("data responses wrong");
    a_prdata: assert property (@(posedge clk) disable iff (!rst_n)
        prdata == exp_prdata) else fail_check("APB read data wrong");
    a_pslverr: assert property (@(posedge clk) disable iff (!rst_n)
        pslverr == (apb_access && !addr_mapped)) else fail_check("APB slave error wrong");
    a_pready: assert property (@(posedge clk) disable iff (!rst_n)
        pready) else fail_check("APB ready low");
    a_irq: assert property (@(posedge clk) disable iff (!rst_n)
        irq == exp_irq) else fail_check("interrupt level wrong");

    task automatic take_random(input int nbits, output logic [PW-1:0] value);
        value = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr     = lfsr_step(lfsr);
            value[i] = lfsr[0];
        end
    endtask

    task automatic drive_responses();
        logic [PW-1:0] r;
        for (int k = 0; k < `LS_NHARTS; k++) begin
            take_random(RW, r);
            mem_instr_resp[k] = r[RW-1:0];
            take_random(RW, r);
            mem_data_resp[k] = r[RW-1:0];
        end
    endtask

    // Same random request on all harts
    task automatic drive_lockstep();
        logic [PW-1:0] ri, rd;
        take_random(IW, ri);
        take_random(PW, rd);
        @(negedge clk);
        for (int k = 0; k < `LS_NHARTS; k++) begin
            core_instr_req[k] = ri[IW-1:0];
            core_data_req[k]  = rd;
        end
        drive_responses();
    endtask

    task automatic drive_diverse();
        logic [PW-1:0] r;
        @(negedge clk);
        for (int k = 0; k < `LS_NHARTS; k++) begin
            take_random(IW, r);
            core_instr_req[k] = r[IW-1:0];
            take_random(PW, r);
            core_data_req[k] = r;
        end
        drive_responses();
    endtask

    task automatic apb_xfer(input logic [3:0] addr, input logic wr, input logic [31:0] wdata,
                            output logic [31:0] rdata);
        @(negedge clk);
        paddr   = addr;
        pwrite  = wr;
        pwdata  = wdata;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        rdata   = prdata;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [3:0] addr, input logic [31:0] wdata);
        logic [31:0] unused;
        apb_xfer(addr, 1'b1, wdata, unused);
    endtask

    task automatic expect_read(input logic [3:0] addr, input logic [31:0] expected);
        logic [31:0] got;
        apb_xfer(addr, 1'b0, 32'h0, got);
        assert (got == expected)
            else fail_check($sformatf("offset %h read %h, expected %h", addr, got, expected));
    endtask

    initial begin
        #((RST_CYCLES + TEST_CYCLES) * CLK_PERIOD);
        $display("Watchdog expired before the test sequence completed");
        $display("Simulation finished: FAIL");
        $fatal(1, "watchdog timeout");
    end

    initial begin
        lfsr = 32'ha002_3aab;
        {paddr, psel, penable, pwrite, pwdata} = '0;
        core_instr_req = '0;
        core_data_req  = '0;
        mem_instr_resp = '0;
        mem_data_resp  = '0;
        wait (rst_n === 1'b1);

        // Reset values and independent routing
        expect_read(`LS_REG_MODE, 32'h0);
        expect_read(`LS_REG_STATUS, 32'h0);
        expect_read(`LS_REG_IRQ_EN, 32'h0);
        repeat (3) drive_diverse();

        // MODE readback, unused codes, unmapped offset
        apb_write(`LS_REG_MODE, 32'h3f);
        expect_read(`LS_REG_MODE, 32'h3f);
        repeat (2) drive_diverse();
        apb_write(`LS_REG_MODE, 32'h24);
        expect_read(`LS_REG_MODE, 32'h24);
        apb_write(4'hc, 32'hffff_ffff);
        expect_read(`LS_REG_MODE, 32'h24);
        expect_read(4'hc, 32'h0);
        expect_read(`LS_REG_IRQ_EN, 32'h0);

        // TMR on every master value
        for (int m = 0; m < 4; m++) begin
            drive_lockstep();
            apb_write(`LS_REG_MODE, (m << 2) | 32'h1);
            repeat (3) drive_lockstep();
        end

        // One faulty hart at a time, then all three apart
        apb_write(`LS_REG_MODE, 32'h1);
        for (int h = 0; h < 4; h++) begin
            apb_write(`LS_REG_IRQ_EN, 32'h0);
            drive_lockstep();
            apb_write(`LS_REG_STATUS, 32'h1f);
            expect_read(`LS_REG_STATUS, 32'h0);
            if (h < 3) begin
                @(negedge clk);
                core_instr_req[h].addr = ~core_instr_req[h].addr;
                core_data_req[h].wdata = ~core_data_req[h].wdata;
                expect_read(`LS_REG_STATUS, 32'h1 | (32'h4 << h));
                // Clear loses to a live vote error
                apb_write(`LS_REG_STATUS, 32'h1f);
                expect_read(`LS_REG_STATUS, 32'h1 | (32'h4 << h));
            end else begin
                drive_diverse();
                expect_read(`LS_REG_STATUS, 32'h1d);
            end
            apb_write(`LS_REG_IRQ_EN, 32'h1);
            assert (irq) else fail_check("interrupt stayed low after enable");
            drive_lockstep();
            apb_write(`LS_REG_STATUS, 32'h1f);
            assert (!irq) else fail_check("interrupt stayed high after clear");
            expect_read(`LS_REG_STATUS, 32'h0);
        end

        // DMR on every pair code
        apb_write(`LS_REG_IRQ_EN, 32'h2);
        for (int p = 0; p < 4; p++) begin
            drive_lockstep();
            apb_write(`LS_REG_MODE, (p << 4) | 32'h2);
            apb_write(`LS_REG_STATUS, 32'h1f);
            drive_diverse();
            expect_read(`LS_REG_STATUS, 32'h2);
            assert (irq) else fail_check("interrupt low after pair mismatch");
            // Clear loses to a live pair mismatch
            apb_write(`LS_REG_STATUS, 32'h2);
            expect_read(`LS_REG_STATUS, 32'h2);
            drive_lockstep();
            apb_write(`LS_REG_STATUS, 32'h2);
            expect_read(`LS_REG_STATUS, 32'h0);
        end

        apb_write(`LS_REG_MODE, 32'h0);
        drive_diverse();
        repeat (2) @(negedge clk);
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/lockstep_bus_mux.sv */
// *************************************************
// Lockstep bus router
// Steers hart requests to memory ports and memory
// responses back to harts per mode
// *************************************************

`timescale 1ns/1ps
`default_nettype none

`include "lockstep_params.svh"

module lockstep_bus_mux (
    input  wire logic                                    tmr_en_i,
    input  wire logic                                    dmr_en_i,
    input  wire logic [1:0]                              master_i,
    input  wire lockstep_pkg::pair_e                     pair_i,
    input  wire lockstep_pkg::instr_req_t [`LS_NHARTS-1:0] core_instr_req_i,
    input  wire lockstep_pkg::data_req_t  [`LS_NHARTS-1:0] core_data_req_i,
    input  wire lockstep_pkg::instr_req_t                voted_instr_i,
    input  wire lockstep_pkg::data_req_t                 voted_data_i,
    input  wire lockstep_pkg::instr_req_t                cmp_instr_i,
    input  wire lockstep_pkg::data_req_t                 cmp_data_i,
    input  wire lockstep_pkg::bus_resp_t  [`LS_NHARTS-1:0] mem_instr_resp_i,
    input  wire lockstep_pkg::bus_resp_t  [`LS_NHARTS-1:0] mem_data_resp_i,
    output lockstep_pkg::instr_req_t                     pair_instr_a_o,
    output lockstep_pkg::instr_req_t                     pair_instr_b_o,
    output lockstep_pkg::data_req_t                      pair_data_a_o,
    output lockstep_pkg::data_req_t                      pair_data_b_o,
    output lockstep_pkg::instr_req_t      [`LS_NHARTS-1:0] mem_instr_req_o,
    output lockstep_pkg::data_req_t       [`LS_NHARTS-1:0] mem_data_req_o,
    output lockstep_pkg::bus_resp_t       [`LS_NHARTS-1:0] core_instr_resp_o,
    output lockstep_pkg::bus_resp_t       [`LS_NHARTS-1:0] core_data_resp_o
);
    import lockstep_pkg::*;

    logic [1:0] pair_a_idx;
    logic [1:0] pair_b_idx;
    logic [1:0] third_idx;

    // Pair members and the hart left over
    always_comb begin
        case (pair_i)
            PAIR_12: begin
                pair_a_idx = 2'd1;
                pair_b_idx = 2'd2;
                third_idx  = 2'd0;
            end
            PAIR_02: begin
                pair_a_idx = 2'd0;
                pair_b_idx = 2'd2;
                third_idx  = 2'd1;
            end
            default: begin
                pair_a_idx = 2'd0;
                pair_b_idx = 2'd1;
                third_idx  = 2'd2;
            end
        endcase
    end

    assign pair_instr_a_o = core_instr_req_i[pair_a_idx];
    assign pair_instr_b_o = core_instr_req_i[pair_b_idx];
    assign pair_data_a_o  = core_data_req_i[pair_a_idx];
    assign pair_data_b_o  = core_data_req_i[pair_b_idx];

    always_comb begin
        mem_instr_req_o   = '0;
        mem_data_req_o    = '0;
        core_instr_resp_o = mem_instr_resp_i;
        core_data_resp_o  = mem_data_resp_i;
        if (tmr_en_i) begin
            mem_instr_req_o[master_i] = voted_instr_i;
            mem_data_req_o[master_i]  = voted_data_i;
            // All harts see the master port
            for (int k = 0; k < `LS_NHARTS; k++) begin
                core_instr_resp_o[k] = mem_instr_resp_i[master_i];
                core_data_resp_o[k]  = mem_data_resp_i[master_i];
            end
        end else if (dmr_en_i) begin
            mem_instr_req_o[0] = cmp_instr_i;
            mem_data_req_o[0]  = cmp_data_i;
            mem_instr_req_o[1] = core_instr_req_i[third_idx];
            mem_data_req_o[1]  = core_data_req_i[third_idx];
            for (int k = 0; k < `LS_NHARTS; k++) begin
                core_instr_resp_o[k] = mem_instr_resp_i[0];
                core_data_resp_o[k]  = mem_data_resp_i[0];
            end
            // Third hart runs alone on port 1
            core_instr_resp_o[third_idx] = mem_instr_resp_i[1];
            core_data_resp_o[third_idx]  = mem_data_resp_i[1];
        end else begin
            mem_instr_req_o = core_instr_req_i;
            mem_data_req_o  = core_data_req_i;
        end
    end

    // Mode decode in the register block keeps these exclusive
    a_one_mode: assert final (!(tmr_en_i && dmr_en_i))
        else $error("TMR and DMR enabled together");

endmodule

`default_nettype wire

/* verilog/lockstep_comparator.sv */
// *************************************************
// Two-way request comparator
// Forwards the first request, flags any mismatch
// *************************************************

`timescale 1ns/1ps
`default_nettype none

module lockstep_comparator #(
    parameter type payload_t = logic
) (
    input  wire logic     enable_i,
    input  wire payload_t a_i,
    input  wire payload_t b_i,
    output payload_t      cmp_o,
    output logic          error_o
);

    logic mismatch;

    assign mismatch = (a_i != b_i);

    // First hart of the pair drives the bus
    assign cmp_o   = a_i;
    assign error_o = enable_i & mismatch;

    // Without a flagged mismatch the forwarded request matches both harts
    a_agree: assert final (!enable_i || error_o || (cmp_o == b_i))
        else $error("Forwarded request differs from the second hart");

endmodule

`default_nettype wire

/* verilog/lockstep_csr.sv */
// *************************************************
// Lockstep register block
// APB access to mode, sticky error status and the
// interrupt enable, plus the error interrupt
// *************************************************

`timescale 1ns/1ps
`default_nettype none

`include "lockstep_params.svh"

module lockstep_csr (
    input  wire logic                   clk_i,
    input  wire logic                   rst_ni,
    input  wire logic [`LS_APB_AW-1:0]  paddr_i,
    input  wire logic                   psel_i,
    input  wire logic                   penable_i,
    input  wire logic                   pwrite_i,
    input  wire logic [`LS_DATA_W-1:0]  pwdata_i,
    output logic      [`LS_DATA_W-1:0]  prdata_o,
    output logic                        pready_o,
    output logic                        pslverr_o,
    input  wire logic                   tmr_error_i,
    input  wire logic                   dmr_error_i,
    input  wire logic [2:0]             error_id_i,
    output logic                        tmr_en_o,
    output logic                        dmr_en_o,
    output logic      [1:0]             master_o,
    output lockstep_pkg::pair_e         pair_o,
    output logic                        interrupt_o
);
    import lockstep_pkg::*;

    logic       access;
    logic       addr_hit;
    logic       mode_wr;
    logic       status_wr;
    logic       irq_en_wr;

    // Raw MODE fields, read back exactly as written
    logic [1:0] mode_q;
    logic [1:0] master_q;
    logic [1:0] pair_q;

    logic       tmr_err_q;
    logic       dmr_err_q;
    logic [2:0] err_id_q;
    logic [1:0] irq_en_q;

    assign access    = psel_i & penable_i;
    assign addr_hit  = (paddr_i == `LS_REG_MODE) || (paddr_i == `LS_REG_STATUS) ||
                       (paddr_i == `LS_REG_IRQ_EN);
    assign mode_wr   = access & pwrite_i & (paddr_i == `LS_REG_MODE);
    assign status_wr = access & pwrite_i & (paddr_i == `LS_REG_STATUS);
    assign irq_en_wr = access & pwrite_i & (paddr_i == `LS_REG_IRQ_EN);

    // No wait states
    assign pready_o  = 1'b1;
    assign pslverr_o = access & ~addr_hit;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mode_q   <= MODE_INDEP;
            master_q <= 2'd0;
            pair_q   <= PAIR_01;
            irq_en_q <= 2'b00;
        end else begin
            if (mode_wr) begin
                mode_q   <= pwdata_i[1:0];
                master_q <= pwdata_i[3:2];
                pair_q   <= pwdata_i[5:4];
            end
            if (irq_en_wr) begin
                irq_en_q <= pwdata_i[1:0];
            end
        end
    end

    // Sticky errors, a live error wins over write-one-to-clear
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            tmr_err_q <= 1'b0;
            dmr_err_q <= 1'b0;
            err_id_q  <= 3'b000;
        end else begin
            if (tmr_error_i) begin
                tmr_err_q <= 1'b1;
                err_id_q  <= error_id_i;
            end else if (status_wr) begin
                tmr_err_q <= tmr_err_q & ~pwdata_i[0];
                err_id_q  <= err_id_q & ~pwdata_i[4:2];
            end
            if (dmr_error_i) begin
                dmr_err_q <= 1'b1;
            end else if (status_wr && pwdata_i[1]) begin
                dmr_err_q <= 1'b0;
            end
        end
    end

    always_comb begin
        prdata_o = '0;
        case (paddr_i)
            `LS_REG_MODE:   prdata_o[5:0] = {pair_q, master_q, mode_q};
            `LS_REG_STATUS: prdata_o[4:0] = {err_id_q, dmr_err_q, tmr_err_q};
            `LS_REG_IRQ_EN: prdata_o[1:0] = irq_en_q;
            default:        prdata_o      = '0;
        endcase
    end

    // Mode decode, code 3 routes as independent
    assign tmr_en_o = (mode_q == MODE_TMR);
    assign dmr_en_o = (mode_q == MODE_DMR);

    // Out-of-range master routes to port 0
    assign master_o = (master_q > 2'd2) ? 2'd0 : master_q;
    assign pair_o   = (pair_q == 2'd3) ? PAIR_01 : pair_e'(pair_q);

    assign interrupt_o = |({dmr_err_q, tmr_err_q} & irq_en_q);

    // Error flags only come from the checker of the active mode
    a_err_mode: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (!tmr_error_i || tmr_en_o) && (!dmr_error_i || dmr_en_o))
        else $error("Error flag raised outside its mode");

endmodule

`default_nettype wire

/* verilog/lockstep_params.svh */
// *************************************************
// Lockstep wrapper parameters
// Hart count, bus widths and APB register offsets
// *************************************************

`ifndef LOCKSTEP_PARAMS_SVH
`define LOCKSTEP_PARAMS_SVH

`define LS_NHARTS     3
`define LS_ADDR_W     32
`define LS_DATA_W     32
`define LS_APB_AW     4
`define LS_REG_MODE   4'h0
`define LS_REG_STATUS 4'h4
`define LS_REG_IRQ_EN 4'h8

`endif

/* verilog/lockstep_pkg.sv */
// *************************************************
// Lockstep wrapper types
// Bus request and response structs, mode encodings
// *************************************************

`default_nettype none

`include "lockstep_params.svh"

package lockstep_pkg;

    // Instruction fetch request, 33 bits
    typedef struct packed {
        logic                  req;
        logic [`LS_ADDR_W-1:0] addr;
    } instr_req_t;

    // Data request, 70 bits
    typedef struct packed {
        logic                  req;
        logic                  we;
        logic [3:0]            be;
        logic [`LS_ADDR_W-1:0] addr;
        logic [`LS_DATA_W-1:0] wdata;
    } data_req_t;

    // Shared response for both buses
    typedef struct packed {
        logic                  gnt;
        logic                  rvalid;
        logic [`LS_DATA_W-1:0] rdata;
    } bus_resp_t;

    // Code 3 falls back to independent
    typedef enum logic [1:0] {
        MODE_INDEP = 2'd0,
        MODE_TMR   = 2'd1,
        MODE_DMR   = 2'd2
    } mode_e;

    // Code 3 falls back to PAIR_01
    typedef enum logic [1:0] {
        PAIR_01 = 2'd0,
        PAIR_12 = 2'd1,
        PAIR_02 = 2'd2
    } pair_e;

endpackage

`default_nettype wire

/* verilog/lockstep_voter.sv */
// *************************************************
// Three-way majority voter
// Votes one request payload and flags the outlier
// *************************************************

`timescale 1ns/1ps
`default_nettype none

module lockstep_voter #(
    parameter type payload_t = logic
) (
    input  wire logic           enable_i,
    input  wire payload_t [2:0] req_i,
    output payload_t            voted_o,
    output logic                error_o,
    output logic      [2:0]     error_id_o
);

    logic eq_01;
    logic eq_12;
    logic eq_02;

    assign eq_01 = (req_i[0] == req_i[1]);
    assign eq_12 = (req_i[1] == req_i[2]);
    assign eq_02 = (req_i[0] == req_i[2]);

    always_comb begin
        // Hart 0 agrees with someone, or nobody agrees
        if (eq_01 || eq_02) begin
            voted_o = req_i[0];
        end else if (eq_12) begin
            voted_o = req_i[1];
        end else begin
            voted_o = req_i[0];
        end
    end

    always_comb begin
        if (eq_01 && eq_12) begin
            error_id_o = 3'b000;
        end else if (eq_01) begin
            error_id_o = 3'b100;
        end else if (eq_02) begin
            error_id_o = 3'b010;
        end else if (eq_12) begin
            error_id_o = 3'b001;
        end else begin
            error_id_o = 3'b111;
        end
    end

    assign error_o = enable_i & (|error_id_o);

    // Unless all three differ, the vote agrees with at least two harts
    a_majority: assert final ((error_id_o == 3'b111) ||
        ((voted_o == req_i[0]) && ((voted_o == req_i[1]) || (voted_o == req_i[2]))) ||
        ((voted_o == req_i[1]) && (voted_o == req_i[2])))
        else $error("Voted request lacks a majority");

endmodule

`default_nettype wire

/* verilog/safe_lockstep_top.sv */
// *************************************************
// Lockstep bus wrapper for three harts
// Register block, voters, comparators and routing
// *************************************************

`timescale 1ns/1ps
`default_nettype none

`include "lockstep_params.svh"

module safe_lockstep_top (
    input  wire logic                                    clk_i,
    input  wire logic                                    rst_ni,
    input  wire logic [`LS_APB_AW-1:0]                   paddr_i,
    input  wire logic                                    psel_i,
    input  wire logic                                    penable_i,
    input  wire logic                                    pwrite_i,
    input  wire logic [`LS_DATA_W-1:0]                   pwdata_i,
    output logic      [`LS_DATA_W-1:0]                   prdata_o,
    output logic                                         pready_o,
    output logic                                         pslverr_o,
    input  wire lockstep_pkg::instr_req_t [`LS_NHARTS-1:0] core_instr_req_i,
    input  wire lockstep_pkg::data_req_t  [`LS_NHARTS-1:0] core_data_req_i,
    output lockstep_pkg::bus_resp_t       [`LS_NHARTS-1:0] core_instr_resp_o,
    output lockstep_pkg::bus_resp_t       [`LS_NHARTS-1:0] core_data_resp_o,
    output lockstep_pkg::instr_req_t      [`LS_NHARTS-1:0] mem_instr_req_o,
    output lockstep_pkg::data_req_t       [`LS_NHARTS-1:0] mem_data_req_o,
    input  wire lockstep_pkg::bus_resp_t  [`LS_NHARTS-1:0] mem_instr_resp_i,
    input  wire lockstep_pkg::bus_resp_t  [`LS_NHARTS-1:0] mem_data_resp_i,
    output logic                                         interrupt_o
);
    import lockstep_pkg::*;

    logic       tmr_en;
    logic       dmr_en;
    logic [1:0] master;
    pair_e      pair;

    instr_req_t voted_instr;
    data_req_t  voted_data;
    logic       instr_vote_err;
    logic       data_vote_err;
    logic [2:0] instr_err_id;
    logic [2:0] data_err_id;

    instr_req_t pair_instr_a;
    instr_req_t pair_instr_b;
    data_req_t  pair_data_a;
    data_req_t  pair_data_b;
    instr_req_t cmp_instr;
    data_req_t  cmp_data;
    logic       instr_cmp_err;
    logic       data_cmp_err;

    lockstep_csr i_csr (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .paddr_i     (paddr_i),
        .psel_i      (psel_i),
        .penable_i   (penable_i),
        .pwrite_i    (pwrite_i),
        .pwdata_i    (pwdata_i),
        .prdata_o    (prdata_o),
        .pready_o    (pready_o),
        .pslverr_o   (pslverr_o),
        .tmr_error_i (instr_vote_err | data_vote_err),
        .dmr_error_i (instr_cmp_err | data_cmp_err),
        .error_id_i  (instr_err_id | data_err_id),
        .tmr_en_o    (tmr_en),
        .dmr_en_o    (dmr_en),
        .master_o    (master),
        .pair_o      (pair),
        .interrupt_o (interrupt_o)
    );

    lockstep_voter #(.payload_t(instr_req_t)) i_instr_voter (
        .enable_i   (tmr_en),
        .req_i      (core_instr_req_i),
        .voted_o    (voted_instr),
        .error_o    (instr_vote_err),
        .error_id_o (instr_err_id)
    );

    lockstep_voter #(.payload_t(data_req_t)) i_data_voter (
        .enable_i   (tmr_en),
        .req_i      (core_data_req_i),
        .voted_o    (voted_data),
        .error_o    (data_vote_err),
        .error_id_o (data_err_id)
    );

    lockstep_comparator #(.payload_t(instr_req_t)) i_instr_cmp (
        .enable_i (dmr_en),
        .a_i      (pair_instr_a),
        .b_i      (pair_instr_b),
        .cmp_o    (cmp_instr),
        .error_o  (instr_cmp_err)
    );

    lockstep_comparator #(.payload_t(data_req_t)) i_data_cmp (
        .enable_i (dmr_en),
        .a_i      (pair_data_a),
        .b_i      (pair_data_b),
        .cmp_o    (cmp_data),
        .error_o  (data_cmp_err)
    );

    lockstep_bus_mux i_bus_mux (
        .tmr_en_i          (tmr_en),
        .dmr_en_i          (dmr_en),
        .master_i          (master),
        .pair_i            (pair),
        .core_instr_req_i  (core_instr_req_i),
        .core_data_req_i   (core_data_req_i),
        .voted_instr_i     (voted_instr),
        .voted_data_i      (voted_data),
        .cmp_instr_i       (cmp_instr),
        .cmp_data_i        (cmp_data),
        .mem_instr_resp_i  (mem_instr_resp_i),
        .mem_data_resp_i   (mem_data_resp_i),
        .pair_instr_a_o    (pair_instr_a),
        .pair_instr_b_o    (pair_instr_b),
        .pair_data_a_o     (pair_data_a),
        .pair_data_b_o     (pair_data_b),
        .mem_instr_req_o   (mem_instr_req_o),
        .mem_data_req_o    (mem_data_req_o),
        .core_instr_resp_o (core_instr_resp_o),
        .core_data_resp_o  (core_data_resp_o)
    );

endmodule

`default_nettype wire
